// ==== files.f ====
+incdir+design
design/cw_route_pkg.sv
design/cw_reg_file.sv
design/trigger_combine.sv
design/targetio_pin_route.sv
design/io_sample_rx.sv
design/cw_io_top.sv
bench/cw_io_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cw_io_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/cw_io_tb.sv ====
`timescale 1ns/10ps
`include "cw_macros.svh"

module cw_io_tb;

   localparam int PIN_N = `CW_NUM_TARGETIO;

   logic                       clk_usb;
   logic                       reset;
   logic [7:0]                 reg_address_i;
   logic [`CW_BYTECNT_W-1:0]   reg_bytecnt_i;
   logic [7:0]                 reg_datai_i;
   logic                       reg_read_i;
   logic                       reg_write_i;
   logic [7:0]                 reg_datao_o;
   logic                       cwauxio_o;
   logic                       trigger_aux_i, trigger_nrst_i, trigger_advio_i, trigger_sad_i;
   logic                       trigger_decodedio_i, trigger_trace_i, trigger_adc_i;
   logic                       trigger_edge_i;
   logic [PIN_N-1:0]           trigger_io_i;
   logic [`CW_USERIO_W-1:0]    userio_d_i;
   logic                       trigger_o, trigger_ext_o;
   logic                       decodeio_active_o, sad_active_o, edge_trigger_active_o;
   logic                       uart_tx_i, uart_rx_o;
   logic [PIN_N-1:0]           targetio_in_i, targetio_out_o, targetio_oe_o;
   logic                       targetpower_off_o, enable_avrprog_o;
   logic                       enable_output_nrst_o, output_nrst_o;
   logic                       enable_output_pdid_o, output_pdid_o;
   logic                       enable_output_pdic_o, output_pdic_o;

   logic [7:0]       aux_m, trigmod_m;          // reference copies of host registers
   logic [15:0]      trigsrc_m;
   logic [63:0]      route_m;
   logic             pwr_m;                     // power bit as the pins see it one cycle late
   logic [PIN_N-1:0] pins_prev;                 // pin levels at the previous edge
   logic             rd_chk, io_chk, pwr_pulse;
   logic [7:0]       rd_exp;
   logic             exp_ext, exp_trig, exp_rx, any_hi, all_hi, found;
   logic [2:0]       exp_flags, act_flags;
   logic [15:0]      src_lvl;
   logic [7:0]       pb, exp_static, act_static;
   logic [PIN_N-1:0] exp_out, exp_oe;
   logic [31:0]      rnd;
   integer           seed, errors, cycles, n;

   cw_io_top DUT (.*);

   initial begin
      clk_usb = 1'b0;
      forever #4 clk_usb = ~clk_usb;            // 125 MHz
   end

   always @(posedge clk_usb) begin
      pwr_m     <= route_m[41];                 // power_off field of the extra byte
      pins_prev <= targetio_in_i;
      if (!reset) cycles <= cycles + 1;
   end

   // only enabled sources take part in the external combine
   always_comb begin
      src_lvl = {userio_d_i, 2'b00, trigger_io_i, trigger_nrst_i, trigger_aux_i};
      any_hi  = 1'b0;
      all_hi  = 1'b1;
      for (int b = 0; b < 16; b++) begin
         if (b != 6 && b != 7 && trigsrc_m[b]) begin     // bits 7:6 hold the mode
            any_hi = any_hi | src_lvl[b];
            all_hi = all_hi & src_lvl[b];
         end
      end
      case (trigsrc_m[7:6])
         `CW_COMB_OR:   exp_ext = any_hi;
         `CW_COMB_AND:  exp_ext = all_hi;
         `CW_COMB_NAND: exp_ext = !all_hi;
         default:       exp_ext = 1'b0;
      endcase
      case (trigmod_m[2:0])
         `CW_TRIGMOD_EDGE_NORMAL: exp_trig = exp_ext;
         `CW_TRIGMOD_ADVIO:       exp_trig = trigger_advio_i;
         `CW_TRIGMOD_SAD:         exp_trig = trigger_sad_i;
         `CW_TRIGMOD_DECODEDIO:   exp_trig = trigger_decodedio_i;
         `CW_TRIGMOD_TRACE:       exp_trig = trigger_trace_i;
         `CW_TRIGMOD_ADC:         exp_trig = trigger_adc_i;
         `CW_TRIGMOD_EDGE:        exp_trig = trigger_edge_i;
         default:                 exp_trig = 1'b0;
      endcase
      exp_flags = {trigmod_m == 8'd3, trigmod_m == 8'd2, trigmod_m == 8'd6};
      act_flags = {decodeio_active_o, sad_active_o, edge_trigger_active_o};
   end

   // pin priority runs power off, tx, hold low, open collector, gpio
   always_comb begin
      exp_rx = 1'b1;                            // idle when nobody listens
      found  = 1'b0;
      for (int p = 0; p < PIN_N; p++) begin
         pb         = route_m[8*p +: 8];
         exp_out[p] = 1'b0;
         exp_oe[p]  = 1'b0;
         if (!pwr_m) begin
            if (pb[0]) begin
               exp_oe[p]  = 1'b1;
               exp_out[p] = uart_tx_i;
            end else if (p == 2 && pb[4]) begin
               exp_oe[p]  = 1'b1;
            end else if (p == 2 && pb[5]) begin
               exp_oe[p]  = !uart_tx_i;         // only pulls low
            end else if (pb[7]) begin
               exp_oe[p]  = 1'b1;
               exp_out[p] = pb[6];
            end
         end
         if (!found && pb[1]) begin
            exp_rx = targetio_in_i[p];
            found  = 1'b1;
         end
      end
      exp_static = {route_m[53:48], route_m[40], aux_m[0]};
      act_static = {output_pdic_o, enable_output_pdic_o, output_pdid_o,
                    enable_output_pdid_o, output_nrst_o, enable_output_nrst_o,
                    enable_avrprog_o, cwauxio_o};
   end

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
   endtask

   a_read: assert property (@(posedge clk_usb) disable iff (reset)
      rd_chk |-> reg_datao_o == rd_exp)
      else report_mismatch("register readback", $sampled(rd_exp), $sampled(reg_datao_o));
   a_read_idle: assert property (@(posedge clk_usb) disable iff (reset)
      !reg_read_i |-> reg_datao_o == 8'h00)
      else report_mismatch("idle read data", 0, $sampled(reg_datao_o));
   a_ioread: assert property (@(posedge clk_usb) disable iff (reset)
      io_chk |-> reg_datao_o == {4'h0, pins_prev})
      else report_mismatch("pin read register", $sampled(pins_prev), $sampled(reg_datao_o));
   a_trig_ext: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_ext_o == exp_ext)
      else report_mismatch("trigger combine", $sampled(exp_ext), $sampled(trigger_ext_o));
   a_trig_sel: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_o == exp_trig)
      else report_mismatch("module select", $sampled(exp_trig), $sampled(trigger_o));
   a_flags: assert property (@(posedge clk_usb) disable iff (reset)
      act_flags == exp_flags)
      else report_mismatch("active flags", $sampled(exp_flags), $sampled(act_flags));
   a_pin_oe: assert property (@(posedge clk_usb) disable iff (reset)
      targetio_oe_o == exp_oe)
      else report_mismatch("pin enables", $sampled(exp_oe), $sampled(targetio_oe_o));
   a_pin_out: assert property (@(posedge clk_usb) disable iff (reset)
      (targetio_out_o & exp_oe) == (exp_out & exp_oe))   // level only matters when driven
      else report_mismatch("pin levels", $sampled(exp_out), $sampled(targetio_out_o));
   a_rx: assert property (@(posedge clk_usb) disable iff (reset)
      uart_rx_o == exp_rx)
      else report_mismatch("uart rx select", $sampled(exp_rx), $sampled(uart_rx_o));
   a_power: assert property (@(posedge clk_usb) disable iff (reset)
      targetpower_off_o == pwr_m)
      else report_mismatch("power off output", $sampled(pwr_m), $sampled(targetpower_off_o));
   a_static: assert property (@(posedge clk_usb) disable iff (reset)
      act_static == exp_static)
      else report_mismatch("static outputs", $sampled(exp_static), $sampled(act_static));
   a_pwr_seq: assert property (@(posedge clk_usb) disable iff (reset)
      pwr_pulse |-> ##2 (targetpower_off_o && targetio_oe_o == '0))
      else report_mismatch("power off after 2 cycles", 64'h10,
                           {$sampled(targetpower_off_o), $sampled(targetio_oe_o)});

   function automatic logic [7:0] expected_read(input logic [7:0] addr, input logic [6:0] cnt);
      case (addr)
         `CW_AUX_IO_ADDR:  return aux_m;
         `CW_TRIGSRC_ADDR: return trigsrc_m[8*cnt[0] +: 8];
         `CW_TRIGMOD_ADDR: return trigmod_m;
         `CW_IOROUTE_ADDR: return route_m[8*cnt[2:0] +: 8];
         default:          return 8'h00;        // unmapped
      endcase
   endfunction

   task automatic bus_write(input logic [7:0] addr, input logic [6:0] cnt,
                            input logic [7:0] data);
      @(posedge clk_usb);
      #1;
      reg_address_i = addr;
      reg_bytecnt_i = cnt;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      pwr_pulse     = (addr == `CW_IOROUTE_ADDR && cnt == 7'd5 && data[1] && !route_m[41]);
      @(posedge clk_usb);                       // register takes the byte here
      case (addr)
         `CW_AUX_IO_ADDR:  aux_m <= {7'b0, data[0]};
         `CW_TRIGSRC_ADDR: trigsrc_m[8*cnt[0] +: 8] <= data;
         `CW_TRIGMOD_ADDR: trigmod_m <= {5'b0, data[2:0]};
         `CW_IOROUTE_ADDR: route_m[8*cnt[2:0] +: 8] <= data;
         default: ;
      endcase
      #1;
      reg_write_i = 1'b0;
      pwr_pulse   = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] addr, input logic [6:0] cnt);
      @(posedge clk_usb);
      #1;
      reg_address_i = addr;
      reg_bytecnt_i = cnt;
      reg_read_i    = 1'b1;
      rd_exp        = expected_read(addr, cnt);
      rd_chk        = (addr != `CW_IOREAD_ADDR);
      io_chk        = (addr == `CW_IOREAD_ADDR);
      if (addr == `CW_IOREAD_ADDR) begin
         targetio_in_i = ~targetio_in_i;        // pins move while the old sample is read
      end
      @(posedge clk_usb);
      #1;
      reg_read_i = 1'b0;
      rd_chk     = 1'b0;
      io_chk     = 1'b0;
   endtask

   task automatic drive_random_inputs();
      @(posedge clk_usb);
      #1;
      rnd = $random(seed);
      {trigger_aux_i, trigger_nrst_i, trigger_io_i} = rnd[5:0];
      userio_d_i = rnd[13:6];
      {trigger_advio_i, trigger_sad_i, trigger_decodedio_i} = rnd[16:14];
      {trigger_trace_i, trigger_adc_i, trigger_edge_i} = rnd[19:17];
      targetio_in_i = rnd[23:20];
      uart_tx_i     = rnd[24];
   endtask

   task automatic wait_power(input logic level);
      int t;
      t = 0;
      while (targetpower_off_o !== level && t < 20) begin   // 20 cycle limit
         @(posedge clk_usb);
         t++;
      end
      if (targetpower_off_o !== level) begin
         errors++;
         $display("timeout: targetpower_off_o did not reach %0b within 20 cycles", level);
      end
   endtask

   initial begin
      seed = 32'haf9a435a;
      errors = 0;
      cycles = 0;
      reset = 1'b1;
      {reg_address_i, reg_bytecnt_i, reg_datai_i, reg_read_i, reg_write_i} = '0;
      {trigger_aux_i, trigger_nrst_i, trigger_io_i, userio_d_i} = '0;
      {trigger_advio_i, trigger_sad_i, trigger_decodedio_i} = '0;
      {trigger_trace_i, trigger_adc_i, trigger_edge_i} = '0;
      {uart_tx_i, targetio_in_i} = '0;
      {rd_chk, io_chk, pwr_pulse, rd_exp, pwr_m, pins_prev} = '0;
      aux_m     = 8'h00;
      trigmod_m = {5'b0, `CW_TRIGMOD_RESET};
      trigsrc_m = `CW_TRIGSRC_RESET;
      route_m   = `CW_IOROUTE_RESET;
      repeat (8) @(posedge clk_usb);
      #1;
      reset = 1'b0;

      // reset values and then every byte of each register
      bus_read(`CW_AUX_IO_ADDR, 0);
      bus_read(`CW_TRIGMOD_ADDR, 0);
      for (n = 0; n < 2; n++) bus_read(`CW_TRIGSRC_ADDR, 7'(n));
      for (n = 0; n < 8; n++) bus_read(`CW_IOROUTE_ADDR, 7'(n));
      bus_read(8'h00, 0);
      bus_read(8'h26, 0);
      bus_read(8'hff, 3);
      for (n = 0; n < 2; n++) begin
         rnd = $random(seed);
         bus_write(`CW_TRIGSRC_ADDR, 7'(n), rnd[7:0]);
         bus_read(`CW_TRIGSRC_ADDR, 7'(n));
      end
      for (n = 0; n < 8; n++) begin
         rnd = $random(seed);
         bus_write(`CW_IOROUTE_ADDR, 7'(n), rnd[7:0]);
         bus_read(`CW_IOROUTE_ADDR, 7'(n));
      end
      bus_write(`CW_AUX_IO_ADDR, 0, 8'hff);
      bus_read(`CW_AUX_IO_ADDR, 0);
      bus_write(`CW_TRIGMOD_ADDR, 0, 8'h05);
      bus_read(`CW_TRIGMOD_ADDR, 0);
      for (n = 1; n < 8; n++) bus_write(`CW_IOROUTE_ADDR, 7'(n), 8'h00);
      wait_power(1'b0);

      // combine modes with random enables and module 0 selected
      bus_write(`CW_TRIGMOD_ADDR, 0, 8'h00);
      for (n = 0; n < 32; n++) begin
         rnd = $random(seed);
         bus_write(`CW_TRIGSRC_ADDR, 0, {n[1:0], rnd[5:0]});
         bus_write(`CW_TRIGSRC_ADDR, 1, rnd[15:8]);
         repeat (4) drive_random_inputs();
      end

      // every module code including 7
      bus_write(`CW_TRIGSRC_ADDR, 0, 8'h3f);
      for (n = 0; n < 8; n++) begin
         bus_write(`CW_TRIGMOD_ADDR, 0, 8'(n));
         repeat (6) drive_random_inputs();
      end

      // random routing bytes on pins 1..4
      for (n = 0; n < 48; n++) begin
         rnd = $random(seed);
         bus_write(`CW_IOROUTE_ADDR, {5'b0, rnd[9:8]}, rnd[7:0]);
         repeat (3) drive_random_inputs();
      end
      rnd = $random(seed);
      bus_write(`CW_IOROUTE_ADDR, 6, rnd[7:0]);       // nrst/pdid/pdic pairs
      bus_write(`CW_IOROUTE_ADDR, 5, 8'h01);          // avr programming on
      drive_random_inputs();
      bus_write(`CW_IOROUTE_ADDR, 5, 8'h02);          // target power off
      wait_power(1'b1);
      repeat (4) drive_random_inputs();
      bus_write(`CW_IOROUTE_ADDR, 5, 8'h00);
      wait_power(1'b0);

      // rx pick and pin sampling
      for (n = 0; n < 40; n++) begin
         rnd = $random(seed);
         bus_write(`CW_IOROUTE_ADDR, {5'b0, rnd[9:8]}, {6'b0, rnd[1:0]});
         drive_random_inputs();
         bus_read(`CW_IOREAD_ADDR, 0);
      end
      for (n = 0; n < 4; n++) bus_write(`CW_IOROUTE_ADDR, 7'(n), 8'h00);
      repeat (4) drive_random_inputs();
      bus_read(`CW_IOREAD_ADDR, 0);

      repeat (2) @(posedge clk_usb);
      $display("checked %0d cycles, %0d errors", cycles, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== design/cw_io_top.sv ====
`timescale 1ns/10ps
`include "cw_macros.svh"

module cw_io_top (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  logic [7:0]                    reg_address_i,
   input  logic [`CW_BYTECNT_W-1:0]      reg_bytecnt_i,
   input  logic [7:0]                    reg_datai_i,
   input  logic                          reg_read_i,
   input  logic                          reg_write_i,
   output logic [7:0]                    reg_datao_o,
   output logic                          cwauxio_o,
   input  logic                          trigger_aux_i,
   input  logic                          trigger_nrst_i,
   input  logic [`CW_NUM_TARGETIO-1:0]   trigger_io_i,
   input  logic [`CW_USERIO_W-1:0]       userio_d_i,
   input  logic                          trigger_advio_i,
   input  logic                          trigger_sad_i,
   input  logic                          trigger_decodedio_i,
   input  logic                          trigger_trace_i,
   input  logic                          trigger_adc_i,
   input  logic                          trigger_edge_i,
   output logic                          trigger_o,
   output logic                          trigger_ext_o,
   output logic                          decodeio_active_o,
   output logic                          sad_active_o,
   output logic                          edge_trigger_active_o,
   input  logic                          uart_tx_i,
   output logic                          uart_rx_o,
   input  logic [`CW_NUM_TARGETIO-1:0]   targetio_in_i,
   output logic [`CW_NUM_TARGETIO-1:0]   targetio_out_o,
   output logic [`CW_NUM_TARGETIO-1:0]   targetio_oe_o,
   output logic                          targetpower_off_o,
   output logic                          enable_avrprog_o,
   output logic                          enable_output_nrst_o,
   output logic                          output_nrst_o,
   output logic                          enable_output_pdid_o,
   output logic                          output_pdid_o,
   output logic                          enable_output_pdic_o,
   output logic                          output_pdic_o
);

   import cw_route_pkg::*;

   ioroute_u                            ioroute;
   logic [`CW_TRIGSRC_W-1:0]            trigsrc;
   logic [`CW_TRIGMOD_W-1:0]            trigmod;
   logic                                targetio_highz;
   logic [`CW_NUM_TARGETIO-1:0]         ioread;    // sampled levels back to regs
   logic [`CW_NUM_TARGETIO-1:0]         rx_en;

   cw_reg_file u_regs (
      .clk_usb, .reset, .reg_address_i, .reg_bytecnt_i, .reg_datai_i,
      .reg_read_i, .reg_write_i, .ioread_i(ioread), .reg_datao_o, .cwauxio_o,
      .trigsrc_o(trigsrc), .trigmod_o(trigmod), .ioroute_o(ioroute),
      .targetio_highz_o(targetio_highz), .targetpower_off_o, .enable_avrprog_o,
      .enable_output_nrst_o, .output_nrst_o, .enable_output_pdid_o,
      .output_pdid_o, .enable_output_pdic_o, .output_pdic_o
   );

   trigger_combine u_trig (
      .clk_usb, .reset, .trigsrc_i(trigsrc), .trigmod_i(trigmod),
      .trigger_aux_i, .trigger_nrst_i, .trigger_io_i, .userio_d_i,
      .trigger_advio_i, .trigger_sad_i, .trigger_decodedio_i, .trigger_trace_i,
      .trigger_adc_i, .trigger_edge_i, .trigger_o, .trigger_ext_o,
      .decodeio_active_o, .sad_active_o, .edge_trigger_active_o
   );

   // one router per target pin
   for (genvar gi = 0; gi < `CW_NUM_TARGETIO; gi++) begin : g_pin
      assign rx_en[gi] = ioroute.field.pin[gi].rx_en;
      targetio_pin_route #(.pPIN_INDEX(gi)) u_route (
         .clk_usb,
         .route_i   (ioroute.field.pin[gi]),
         .highz_i   (targetio_highz),
         .uart_tx_i,
         .pin_out_o (targetio_out_o[gi]),
         .pin_oe_o  (targetio_oe_o[gi])
      );
   end

   io_sample_rx u_rx (
      .clk_usb, .reset, .pin_in_i(targetio_in_i), .rx_en_i(rx_en),
      .ioread_o(ioread), .uart_rx_o
   );

endmodule

// ==== design/io_sample_rx.sv ====
`timescale 1ns/10ps
`include "cw_macros.svh"

module io_sample_rx (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  logic [`CW_NUM_TARGETIO-1:0]   pin_in_i,   // pad levels
   input  logic [`CW_NUM_TARGETIO-1:0]   rx_en_i,    // per-pin rx enable
   output logic [`CW_NUM_TARGETIO-1:0]   ioread_o,   // for host readback
   output logic                          uart_rx_o
);

   logic [`CW_NUM_TARGETIO-1:0] ioread_q;

   // one cycle sample of the pins
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_q <= '0;
      end else begin
         ioread_q <= pin_in_i;
      end
   end

   assign ioread_o = ioread_q;

   // lowest enabled pin wins, scanned from the top down
   always_comb begin
      uart_rx_o = 1'b1;                              // idle line
      for (int i = `CW_NUM_TARGETIO-1; i >= 0; i--) begin
         if (rx_en_i[i]) begin
            uart_rx_o = pin_in_i[i];
         end
      end
   end

endmodule

// ==== design/targetio_pin_route.sv ====
`timescale 1ns/10ps
`include "cw_macros.svh"

module targetio_pin_route #(
   parameter int pPIN_INDEX = 0                    // 0-based pin number
) (
   input  logic                        clk_usb,
   input  cw_route_pkg::gpio_route_t   route_i,    // this pin's routing byte
   input  logic                        highz_i,    // target power off
   input  logic                        uart_tx_i,
   output logic                        pin_out_o,
   output logic                        pin_oe_o
);

   // only pin 3 has the open-collector and hold-low options
   localparam bit HAS_OC = (pPIN_INDEX == 2);

   always_comb begin
      pin_out_o = 1'b0;
      pin_oe_o  = 1'b0;                              // float by default
      if (highz_i) begin
         pin_oe_o = 1'b0;                            // unpowered target, hands off
      end else if (route_i.tx_en) begin
         pin_out_o = uart_tx_i;
         pin_oe_o  = 1'b1;
      end else if (HAS_OC && route_i.const_low) begin
         pin_out_o = 1'b0;
         pin_oe_o  = 1'b1;
      end else if (HAS_OC && route_i.oc_tx) begin
         pin_out_o = 1'b0;                           // pull low only
         pin_oe_o  = ~uart_tx_i;                     // release on tx high
      end else if (route_i.gpio_en) begin
         pin_out_o = route_i.gpio_level;
         pin_oe_o  = 1'b1;
      end
   end

   // pin must stay released whenever power is off
   a_highz_float: assert property (@(posedge clk_usb) highz_i |-> !pin_oe_o);

endmodule

// ==== design/trigger_combine.sv ====
`timescale 1ns/10ps
`include "cw_macros.svh"

module trigger_combine (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  logic [`CW_TRIGSRC_W-1:0]      trigsrc_i,          // enables + mode
   input  logic [`CW_TRIGMOD_W-1:0]      trigmod_i,
   input  logic                          trigger_aux_i,      // front aux line
   input  logic                          trigger_nrst_i,
   input  logic [`CW_NUM_TARGETIO-1:0]   trigger_io_i,       // rear target lines
   input  logic [`CW_USERIO_W-1:0]       userio_d_i,
   input  logic                          trigger_advio_i,
   input  logic                          trigger_sad_i,
   input  logic                          trigger_decodedio_i,
   input  logic                          trigger_trace_i,
   input  logic                          trigger_adc_i,
   input  logic                          trigger_edge_i,
   output logic                          trigger_o,
   output logic                          trigger_ext_o,
   output logic                          decodeio_active_o,
   output logic                          sad_active_o,
   output logic                          edge_trigger_active_o
);

   logic [`CW_TRIGSRC_W-1:0] src;        // sources lined up with enable bits
   logic [`CW_TRIGSRC_W-1:0] src_en;     // mode bits masked out
   logic [1:0]               comb_mode;
   logic                     trig_or;
   logic                     trig_and;

   assign src       = {userio_d_i, 2'b00, trigger_io_i, trigger_nrst_i, trigger_aux_i};
   assign src_en    = {trigsrc_i[15:8], 2'b00, trigsrc_i[5:0]};
   assign comb_mode = trigsrc_i[7:6];

   assign trig_or  = |(src & src_en);       // disabled counts as 0
   assign trig_and = &(src | ~src_en);      // disabled counts as 1

   always_comb begin
      case (comb_mode)
         `CW_COMB_OR:   trigger_ext_o = trig_or;
         `CW_COMB_AND:  trigger_ext_o = trig_and;
         `CW_COMB_NAND: trigger_ext_o = ~trig_and;
         default:       trigger_ext_o = 1'b0;   // combine off
      endcase
   end

   // trigger module select
   always_comb begin
      case (trigmod_i)
         `CW_TRIGMOD_EDGE_NORMAL: trigger_o = trigger_ext_o;
         `CW_TRIGMOD_ADVIO:       trigger_o = trigger_advio_i;
         `CW_TRIGMOD_SAD:         trigger_o = trigger_sad_i;
         `CW_TRIGMOD_DECODEDIO:   trigger_o = trigger_decodedio_i;
         `CW_TRIGMOD_TRACE:       trigger_o = trigger_trace_i;
         `CW_TRIGMOD_ADC:         trigger_o = trigger_adc_i;
         `CW_TRIGMOD_EDGE:        trigger_o = trigger_edge_i;
         default:                 trigger_o = 1'b0;   // code 7 unused
      endcase
   end

   // modules that need to know they own the trigger
   assign decodeio_active_o     = (trigmod_i == `CW_TRIGMOD_DECODEDIO);
   assign sad_active_o          = (trigmod_i == `CW_TRIGMOD_SAD);
   assign edge_trigger_active_o = (trigmod_i == `CW_TRIGMOD_EDGE);

   a_one_active: assert property (@(posedge clk_usb) disable iff (reset)
      $onehot0({decodeio_active_o, sad_active_o, edge_trigger_active_o}));

endmodule

// ==== design/cw_reg_file.sv ====
`timescale 1ns/10ps
`include "cw_macros.svh"

module cw_reg_file (
   input  logic                          clk_usb,
   input  logic                          reset,
   input  logic [7:0]                    reg_address_i,
   input  logic [`CW_BYTECNT_W-1:0]      reg_bytecnt_i,
   input  logic [7:0]                    reg_datai_i,
   input  logic                          reg_read_i,
   input  logic                          reg_write_i,
   input  logic [`CW_NUM_TARGETIO-1:0]   ioread_i,        // sampled pin levels
   output logic [7:0]                    reg_datao_o,
   output logic                          cwauxio_o,
   output logic [`CW_TRIGSRC_W-1:0]      trigsrc_o,
   output logic [`CW_TRIGMOD_W-1:0]      trigmod_o,
   output cw_route_pkg::ioroute_u        ioroute_o,
   output logic                          targetio_highz_o,
   output logic                          targetpower_off_o,
   output logic                          enable_avrprog_o,
   output logic                          enable_output_nrst_o,
   output logic                          output_nrst_o,
   output logic                          enable_output_pdid_o,
   output logic                          output_pdid_o,
   output logic                          enable_output_pdic_o,
   output logic                          output_pdic_o
);

   import cw_route_pkg::*;

   logic                                auxio_q;      // aux output enable
   logic [`CW_TRIGSRC_W/8-1:0][7:0]     trigsrc_q;    // byte addressable
   logic [`CW_TRIGMOD_W-1:0]            trigmod_q;
   ioroute_u                            ioroute_q;
   logic                                power_off_q;  // one cycle behind routing bit
   logic                                trig_lane;    // byte select, trigsrc
   logic [2:0]                          route_lane;   // byte select, ioroute

   assign trig_lane  = reg_bytecnt_i[0];
   assign route_lane = reg_bytecnt_i[2:0];

   // host writes, one byte per strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         auxio_q   <= 1'b0;
         trigsrc_q <= `CW_TRIGSRC_RESET;
         trigmod_q <= `CW_TRIGMOD_RESET;
         ioroute_q <= `CW_IOROUTE_RESET;
      end else if (reg_write_i) begin
         case (reg_address_i)
            `CW_AUX_IO_ADDR:  auxio_q <= reg_datai_i[0];
            `CW_TRIGSRC_ADDR: trigsrc_q[trig_lane] <= reg_datai_i;
            `CW_TRIGMOD_ADDR: trigmod_q <= reg_datai_i[`CW_TRIGMOD_W-1:0];
            `CW_IOROUTE_ADDR: ioroute_q.byte_lane[route_lane] <= reg_datai_i;
            default: ;                                   // read-only or unmapped
         endcase
      end
   end

   // read mux, zero when idle or unmapped
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (reg_address_i)
            `CW_AUX_IO_ADDR:  reg_datao_o = {7'b0, auxio_q};
            `CW_TRIGSRC_ADDR: reg_datao_o = trigsrc_q[trig_lane];
            `CW_TRIGMOD_ADDR: reg_datao_o = {{(8-`CW_TRIGMOD_W){1'b0}}, trigmod_q};
            `CW_IOROUTE_ADDR: reg_datao_o = ioroute_q.byte_lane[route_lane];
            `CW_IOREAD_ADDR:  reg_datao_o = {{(8-`CW_NUM_TARGETIO){1'b0}}, ioread_i};
            default:          reg_datao_o = 8'h00;
         endcase
      end
   end

   // power switch and pin float share one flop
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         power_off_q <= 1'b0;
      end else begin
         power_off_q <= ioroute_q.field.extra.power_off;
      end
   end

   assign targetpower_off_o = power_off_q;
   assign targetio_highz_o  = power_off_q;     // pins float while unpowered

   assign cwauxio_o = auxio_q;
   assign trigsrc_o = trigsrc_q;
   assign trigmod_o = trigmod_q;
   assign ioroute_o = ioroute_q;

   // static outputs straight from routing fields
   assign enable_avrprog_o     = ioroute_q.field.extra.avrprog_en;
   assign enable_output_nrst_o = ioroute_q.field.extra_gpio.nrst_en;
   assign output_nrst_o        = ioroute_q.field.extra_gpio.nrst;
   assign enable_output_pdid_o = ioroute_q.field.extra_gpio.pdid_en;
   assign output_pdid_o        = ioroute_q.field.extra_gpio.pdid;
   assign enable_output_pdic_o = ioroute_q.field.extra_gpio.pdic_en;
   assign output_pdic_o        = ioroute_q.field.extra_gpio.pdic;

   // host must keep byte count inside the addressed register
   a_trigsrc_bytecnt: assert property (@(posedge clk_usb) disable iff (reset)
      (reg_write_i && reg_address_i == `CW_TRIGSRC_ADDR) |-> reg_bytecnt_i < `CW_TRIGSRC_W/8);
   a_ioroute_bytecnt: assert property (@(posedge clk_usb) disable iff (reset)
      (reg_write_i && reg_address_i == `CW_IOROUTE_ADDR) |-> reg_bytecnt_i < `CW_IOROUTE_W/8);

endmodule

// ==== design/cw_route_pkg.sv ====
`include "cw_macros.svh"

package cw_route_pkg;

   // one routing byte per target pin
   typedef struct packed {
      logic       gpio_en;     // drive fixed level
      logic       gpio_level;  // level when gpio_en
      logic       oc_tx;       // pin 3 only, tx open collector
      logic       const_low;   // pin 3 only, hold low
      logic [1:0] rsvd_user;   // user serial bits, kept reserved
      logic       rx_en;       // pin feeds uart rx
      logic       tx_en;       // pin driven by uart tx
   } gpio_route_t;

   typedef struct packed {
      logic [5:0] rsvd;        // switch type / smart card, unused
      logic       power_off;   // target power disable
      logic       avrprog_en;  // avr programming mux
   } extra_route_t;

   typedef struct packed {
      logic [1:0] rsvd;
      logic       pdic;
      logic       pdic_en;
      logic       pdid;
      logic       pdid_en;
      logic       nrst;
      logic       nrst_en;
   } extra_gpio_t;

   // field view, lsb byte first in memory order
   typedef struct packed {
      logic [7:0]                              rsvd;        // byte 7
      extra_gpio_t                             extra_gpio;  // byte 6
      extra_route_t                            extra;       // byte 5
      logic [7:0]                              glitch;      // byte 4, outputs dropped
      gpio_route_t [`CW_NUM_TARGETIO-1:0]      pin;         // bytes 3..0
   } ioroute_fields_t;

   // same 64 bits seen as host byte lanes or decoded fields
   typedef union packed {
      logic [`CW_IOROUTE_W/8-1:0][7:0] byte_lane;
      ioroute_fields_t                 field;
   } ioroute_u;

endpackage

// ==== design/cw_macros.svh ====
`ifndef CW_MACROS_SVH
`define CW_MACROS_SVH

// host register map
`define CW_AUX_IO_ADDR      8'h25   // aux output control
`define CW_TRIGSRC_ADDR     8'h27   // trigger source enables + combine mode
`define CW_TRIGMOD_ADDR     8'h28   // trigger module select
`define CW_IOROUTE_ADDR     8'h37   // target pin routing, 8 bytes
`define CW_IOREAD_ADDR      8'h3b   // sampled target pin levels

// widths
`define CW_BYTECNT_W        7       // host byte counter
`define CW_TRIGSRC_W        16      // two bytes
`define CW_TRIGMOD_W        3       // module code only
`define CW_IOROUTE_W        64      // eight bytes
`define CW_NUM_TARGETIO     4       // rear target io pins
`define CW_USERIO_W         8       // user io lines used as triggers

// reset values
`define CW_TRIGSRC_RESET    16'h0020                // pin 4 enabled, or mode
`define CW_TRIGMOD_RESET    3'd0                    // normal edge
`define CW_IOROUTE_RESET    64'h0000_0000_0000_0201 // pin 1 tx, pin 2 rx

// trigger module codes
`define CW_TRIGMOD_EDGE_NORMAL  3'd0  // combined external trigger
`define CW_TRIGMOD_ADVIO        3'd1  // advanced io pattern
`define CW_TRIGMOD_SAD          3'd2  // sum of abs difference
`define CW_TRIGMOD_DECODEDIO    3'd3  // decoded serial io
`define CW_TRIGMOD_TRACE        3'd4  // trace match
`define CW_TRIGMOD_ADC          3'd5  // adc level
`define CW_TRIGMOD_EDGE         3'd6  // edge counter

// combine modes, trigsrc[7:6]; 3 is off
`define CW_COMB_OR          2'd0
`define CW_COMB_AND         2'd1
`define CW_COMB_NAND        2'd2

`endif
